/* design/fetchPkg.sv */
// ====================================================================
// Fetch buffer package
// Widths, opcodes and the shared types of the instruction fetch buffer:
// the decoded instruction word, buffer slots, fetch groups and the
// redirect decision of one predecoder
// ====================================================================

package fetchPkg;

	localparam int AddrWidth = 32;                // instruction address width
	localparam int InsnBytes = 4;                 // fixed instruction length

	typedef logic [AddrWidth-1:0] address_t;

	// ================================================================
	// opcodes seen by the predecoders
	// ================================================================
	localparam logic [5:0] OpBranch0 = 6'h10;    // conditional branch
	localparam logic [5:0] OpBranch1 = 6'h11;    // conditional branch, second form
	localparam logic [5:0] OpJal     = 6'h01;    // jump-and-link
	localparam logic [5:0] OpBrkGrp  = 6'h02;    // break group
	localparam logic [5:0] ExBrk     = 6'h00;    // break sub-opcode

	// one word, three views of the same 32 bits
	typedef union packed {
		struct packed {
			logic [5:0]  opcode;
			logic [9:0]  regs;                    // source registers
			logic [15:0] disp;                    // in words, signed
		} br;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;                  // in words
		} jal;
		struct packed {
			logic [5:0]  opcode;
			logic [19:0] unused;
			logic [5:0]  exop;
		} brk;
	} insn_t;

	typedef struct packed {
		logic     valid;
		address_t adr;
		insn_t    ins;
		logic     predictTaken;
	} fetchSlot_t;                                // 66 bits

	typedef struct packed {
		logic       load;                         // group accepted this cycle
		fetchSlot_t slot0;
		fetchSlot_t slot1;
	} fetchGroup_t;                               // 133 bits

	typedef struct packed {
		logic     take;
		address_t target;
	} redirect_t;                                 // 33 bits

endpackage

/* design/branchTarget.sv */
// ====================================================================
// Branch target predecoder
// Looks at one fetched word and decides whether it redirects fetch,
// and to which address
// ====================================================================
`timescale 1ns/1ps

module branchTarget #(
	parameter fetchPkg::address_t BrkVector = 32'h0000_0100
) (
	input  fetchPkg::insn_t     word,
	input  fetchPkg::address_t  adr,
	input  logic                predictTaken,
	output fetchPkg::redirect_t redirect
);

	fetchPkg::address_t brOffset;
	fetchPkg::address_t fallThrough;

	// word displacement scaled to bytes and sign-extended
	assign brOffset = {{(fetchPkg::AddrWidth-18){word.br.disp[15]}}, word.br.disp, 2'b00};
	assign fallThrough = adr + fetchPkg::AddrWidth'(fetchPkg::InsnBytes);

	always_comb
	begin
		redirect.take = 1'b0;
		redirect.target = fallThrough + brOffset;        // branch form by default
		case (word.br.opcode)
			fetchPkg::OpBranch0,
			fetchPkg::OpBranch1:
				redirect.take = predictTaken;               // only when predicted taken
			fetchPkg::OpJal:
			begin
				redirect.take = 1'b1;
				redirect.target = {adr[fetchPkg::AddrWidth-1 -: 4], word.jal.target, 2'b00};
			end
			fetchPkg::OpBrkGrp:
			begin
				if (word.brk.exop == fetchPkg::ExBrk)
				begin
					redirect.take = 1'b1;
					redirect.target = BrkVector;
				end
			end
			default:
				redirect.take = 1'b0;
		endcase
	end

endmodule

/* design/fetchControl.sv */
// ====================================================================
// Fetch controller
// Owns the fetch address, builds the two-slot group from the cache
// answer and picks the next fetch address from both predecodes
// ====================================================================
`timescale 1ns/1ps

module fetchControl #(
	parameter fetchPkg::address_t ResetPc = 32'h0000_0200
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fetchHit,
	input  fetchPkg::insn_t       insn0,
	input  fetchPkg::insn_t       insn1,
	input  logic                  predictTaken0,
	input  logic                  predictTaken1,
	input  logic                  branchMiss,
	input  fetchPkg::address_t    missPc,
	input  logic                  fetchReady,
	input  fetchPkg::redirect_t   redirect0,
	input  fetchPkg::redirect_t   redirect1,
	output fetchPkg::address_t    fetchPc,
	output fetchPkg::address_t    slotAdr1,
	output fetchPkg::fetchGroup_t group
);

	localparam int AlignBits = $clog2(fetchPkg::InsnBytes);

	logic               accept;
	fetchPkg::address_t nextPc;

	assign accept = fetchHit & fetchReady & ~branchMiss;   // miss wins over a hit
	assign slotAdr1 = fetchPc + fetchPkg::AddrWidth'(fetchPkg::InsnBytes);

	// ================================================================
	// group build
	// ================================================================
	always_comb
	begin
		group.load = accept;
		group.slot0.valid = 1'b1;
		group.slot0.adr = fetchPc;
		group.slot0.ins = insn0;
		group.slot0.predictTaken = predictTaken0;
		group.slot1.valid = ~redirect0.take;             // dead behind a taken slot 0
		group.slot1.adr = slotAdr1;
		group.slot1.ins = insn1;
		group.slot1.predictTaken = predictTaken1;
	end

	// next fetch address, slot 0 has priority
	always_comb
	begin
		if (redirect0.take)
			nextPc = redirect0.target;
		else if (redirect1.take)
			nextPc = redirect1.target;
		else
			nextPc = fetchPc + fetchPkg::AddrWidth'(2 * fetchPkg::InsnBytes);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			fetchPc <= ResetPc;
		else if (branchMiss)
			fetchPc <= missPc;
		else if (accept)
			fetchPc <= nextPc;                              // holds under back-pressure
	end

	// targets, miss addresses and the reset vector must all keep word alignment
	pcAligned: assert property (@(posedge clk) disable iff (rst)
		fetchPc[AlignBits-1:0] == '0);

endmodule

/* design/fetchPairs.sv */
// ====================================================================
// Fetch slot pairs
// Four buffer slots kept as two ping-ponged pairs (AB and CD). One pair
// is offered to the instruction queue while the other one fills
// ====================================================================
`timescale 1ns/1ps

module fetchPairs (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  branchMiss,
	input  fetchPkg::fetchGroup_t group,
	input  logic                  queued1,
	input  logic                  queued2,
	output logic                  fetchReady,
	output fetchPkg::fetchSlot_t  issue0,
	output fetchPkg::fetchSlot_t  issue1
);

	fetchPkg::fetchSlot_t slots [2][2];           // [pair][position], position 0 is oldest
	logic                 activeSel;              // 0 = AB, 1 = CD
	logic                 inactSel;
	logic                 activeEmpty;
	logic                 inactEmpty;
	logic                 loadActive;
	logic                 loadInact;
	logic                 activeDrains;
	logic                 flip;

	assign inactSel = ~activeSel;

	// position 0 is always the valid one when a pair is partly full
	assign activeEmpty = ~slots[activeSel][0].valid;
	assign inactEmpty = ~slots[inactSel][0].valid;
	assign fetchReady = inactEmpty;

	// ================================================================
	// fill and pair select
	// ================================================================
	// fill the active pair directly only when nothing older is buffered
	assign loadActive = group.load & inactEmpty & activeEmpty;
	assign loadInact = group.load & inactEmpty & ~activeEmpty;

	assign activeDrains = queued2 | (queued1 & ~slots[activeSel][1].valid);

	// move over once the active pair runs dry and the other has work
	assign flip = (activeEmpty | activeDrains) & (~inactEmpty | loadInact);

	assign issue0 = slots[activeSel][0];
	assign issue1 = slots[activeSel][1];

	always_ff @(posedge clk)
	begin
		if (rst || branchMiss)
		begin
			for (int p = 0; p < 2; p++)
			begin
				for (int q = 0; q < 2; q++)
					slots[p][q].valid <= 1'b0;
			end
			activeSel <= 1'b0;                      // restart on AB
		end
		else
		begin
			// dequeue, oldest first
			if (queued2)
			begin
				slots[activeSel][0].valid <= 1'b0;
				slots[activeSel][1].valid <= 1'b0;
			end
			else if (queued1)
			begin
				slots[activeSel][0] <= slots[activeSel][1];   // shift the survivor forward
				slots[activeSel][1].valid <= 1'b0;
			end

			if (loadActive)
			begin
				slots[activeSel][0] <= group.slot0;
				slots[activeSel][1] <= group.slot1;
			end

			if (loadInact)
			begin
				slots[inactSel][0] <= group.slot0;
				slots[inactSel][1] <= group.slot1;
			end

			if (flip)
				activeSel <= inactSel;
		end
	end

	// ================================================================
	// queue handshake and slot ordering
	// ================================================================
	queued2NeedsQueued1: assert property (@(posedge clk) disable iff (rst)
		queued2 |-> queued1);

	queued1NeedsValid: assert property (@(posedge clk) disable iff (rst)
		queued1 |-> issue0.valid);

	// loads, shifts and flushes together must keep both pairs packed
	pairsPacked: assert property (@(posedge clk) disable iff (rst)
		!(slots[0][1].valid && !slots[0][0].valid) &&
		!(slots[1][1].valid && !slots[1][0].valid));

endmodule

/* design/fetchBuffer.sv */
// ====================================================================
// Instruction fetch buffer
// Top level: fetch controller, two predecoders and the slot pairs
// ====================================================================
`timescale 1ns/1ps

module fetchBuffer #(
	parameter fetchPkg::address_t ResetPc   = 32'h0000_0200,
	parameter fetchPkg::address_t BrkVector = 32'h0000_0100
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fetchHit,
	input  fetchPkg::insn_t      insn0,
	input  fetchPkg::insn_t      insn1,
	input  logic                 predictTaken0,
	input  logic                 predictTaken1,
	input  logic                 branchMiss,
	input  fetchPkg::address_t   missPc,
	input  logic                 queued1,
	input  logic                 queued2,
	output fetchPkg::address_t   fetchPc,
	output logic                 fetchReady,
	output fetchPkg::fetchSlot_t issue0,
	output fetchPkg::fetchSlot_t issue1
);

	fetchPkg::address_t    slotAdr1;
	fetchPkg::redirect_t   redirect0;
	fetchPkg::redirect_t   redirect1;
	fetchPkg::fetchGroup_t group;

	fetchControl #(.ResetPc(ResetPc)) u_fetchControl (
		.clk(clk), .rst(rst), .fetchHit(fetchHit),
		.insn0(insn0), .insn1(insn1),
		.predictTaken0(predictTaken0), .predictTaken1(predictTaken1),
		.branchMiss(branchMiss), .missPc(missPc), .fetchReady(fetchReady),
		.redirect0(redirect0), .redirect1(redirect1),
		.fetchPc(fetchPc), .slotAdr1(slotAdr1), .group(group)
	);

	// predecode both words of the group side by side
	branchTarget #(.BrkVector(BrkVector)) u_target0 (
		.word(insn0), .adr(fetchPc), .predictTaken(predictTaken0), .redirect(redirect0)
	);

	branchTarget #(.BrkVector(BrkVector)) u_target1 (
		.word(insn1), .adr(slotAdr1), .predictTaken(predictTaken1), .redirect(redirect1)
	);

	fetchPairs u_fetchPairs (
		.clk(clk), .rst(rst), .branchMiss(branchMiss), .group(group),
		.queued1(queued1), .queued2(queued2), .fetchReady(fetchReady),
		.issue0(issue0), .issue1(issue1)
	);

endmodule

/* verif/fetchBufferTb.sv */
// ======================================================================
// Fetch buffer testbench
// Random cache and queue traffic with branch misses. A program-order
// model checks every slot that the queue accepts
// ======================================================================
`timescale 1ns/1ps

module fetchBufferTb;

	localparam fetchPkg::address_t ResetPc   = 32'h0000_0200;
	localparam fetchPkg::address_t BrkVector = 32'h0000_0100;
	localparam int NumIssue  = 2000;
	localparam int MaxCycles = NumIssue * 10;          // about 3 cycles per slot, plenty of slack

	logic clk, rst, fetchHit, predictTaken0, predictTaken1, branchMiss, queued1, queued2;
	fetchPkg::insn_t      insn0, insn1;
	fetchPkg::address_t   missPc, fetchPc;
	logic                 fetchReady;
	fetchPkg::fetchSlot_t issue0, issue1;

	logic [31:0]        imem [1024];                 // indexed by address bits 11 to 2
	integer             seed;
	int                 issuedCount, cycles, buffered, stallLeft;
	fetchPkg::address_t expAdr, lastPc;
	logic               holdPc, accept;

	fetchBuffer #(.ResetPc(ResetPc), .BrkVector(BrkVector)) u_fetchBuffer (
		.clk(clk), .rst(rst), .fetchHit(fetchHit), .insn0(insn0), .insn1(insn1),
		.predictTaken0(predictTaken0), .predictTaken1(predictTaken1),
		.branchMiss(branchMiss), .missPc(missPc), .queued1(queued1), .queued2(queued2),
		.fetchPc(fetchPc), .fetchReady(fetchReady), .issue0(issue0), .issue1(issue1)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;                             // 40 ns period

	// ==================================================================
	// reference rules
	// ==================================================================
	function automatic int unsigned randBelow(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic predictBit(input fetchPkg::address_t adr);
		return adr[2] ^ adr[4] ^ adr[7] ^ adr[10];      // fixed hash of the address
	endfunction

	function automatic logic takes(input logic [31:0] word, input logic pt);
		logic [5:0] op;
		op = word[31:26];
		if (op == fetchPkg::OpBranch0 || op == fetchPkg::OpBranch1)
			return pt;
		if (op == fetchPkg::OpJal)
			return 1'b1;
		return op == fetchPkg::OpBrkGrp && word[5:0] == fetchPkg::ExBrk;
	endfunction

	function automatic fetchPkg::address_t targetOf(input fetchPkg::address_t adr,
		input logic [31:0] word);
		int d;
		d = $signed(word[15:0]);                        // displacement in words
		if (word[31:26] == fetchPkg::OpJal)
			return {adr[31:28], word[25:0], 2'b00};
		if (word[31:26] == fetchPkg::OpBrkGrp)
			return BrkVector;
		return adr + 32'd4 + fetchPkg::address_t'(d * 4);
	endfunction

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic fillMemory;
		int          kind;
		int          d;
		logic [31:0] r;
		for (int i = 0; i < 1024; i++)
		begin
			r = $random(seed);
			kind = randBelow(32);                       // kinds 0 to 3 are control flow
			d = int'(randBelow(64)) - 32;
			case (kind)
				0: imem[i] = {fetchPkg::OpBranch0, r[25:16], 16'(d)};
				1: imem[i] = {fetchPkg::OpBranch1, r[25:16], 16'(d)};
				2: imem[i] = {fetchPkg::OpJal, r[25:0]};
				3: imem[i] = {fetchPkg::OpBrkGrp, r[25:6], r[0] ? fetchPkg::ExBrk : 6'h05};
				default: imem[i] = {1'b1, r[30:0]};     // opcodes 0x20 and up never redirect
			endcase
		end
	endtask

	// compare one accepted slot with the model, then advance the model
	task automatic checkSlot(input string name, input fetchPkg::fetchSlot_t s);
		logic [31:0] word;
		word = imem[expAdr[11:2]];
		assert (s.adr == expAdr)
			else failNow($sformatf("FAIL %s address expected %h actual %h", name, expAdr, s.adr));
		assert (s.ins == word)
			else failNow($sformatf("FAIL %s word expected %h actual %h", name, word, s.ins));
		assert (s.predictTaken == predictBit(expAdr))
			else failNow($sformatf("FAIL %s predictTaken expected %h actual %h", name,
				predictBit(expAdr), s.predictTaken));
		expAdr = takes(word, predictBit(expAdr)) ? targetOf(expAdr, word) : expAdr + 4;
		issuedCount++;
	endtask

	// ==================================================================
	// stimulus and checking, all on the falling edge
	// ==================================================================
	initial
	begin
		seed = 32'he71e;
		rst = 1'b1;
		fetchHit = 1'b0;
		insn0 = '0;
		insn1 = '0;
		predictTaken0 = 1'b0;
		predictTaken1 = 1'b0;
		branchMiss = 1'b0;
		missPc = '0;
		queued1 = 1'b0;
		queued2 = 1'b0;
		issuedCount = 0;
		cycles = 0;
		buffered = 0;
		stallLeft = 0;
		holdPc = 1'b0;
		lastPc = '0;
		expAdr = ResetPc;
		fillMemory();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		assert (fetchPc == ResetPc && !issue0.valid && !issue1.valid && fetchReady)
			else failNow("reset state wrong: fetchPc, issue valids or fetchReady not as expected");

		while (issuedCount < NumIssue)
		begin
			// state left by the last rising edge
			assert (issue0.valid == (buffered != 0))
				else failNow($sformatf("FAIL occupancy expected %h actual %h",
					buffered != 0, issue0.valid));
			if (buffered == 4)
				assert (!fetchReady)
					else failNow($sformatf("FAIL fullReady expected %h actual %h", 1'b0, fetchReady));
			if (holdPc)
				assert (fetchPc == lastPc)
					else failNow($sformatf("FAIL pcHold expected %h actual %h", lastPc, fetchPc));

			// cache answer
			branchMiss = randBelow(60) == 0;
			missPc = {$random(seed)} & 32'hffff_fffc;
			fetchHit = randBelow(10) < 8;
			insn0 = imem[fetchPc[11:2]];
			insn1 = imem[fetchPc[11:2] + 10'd1];
			predictTaken0 = predictBit(fetchPc);
			predictTaken1 = predictBit(fetchPc + 4);

			// queue, with occasional long stalls
			if (stallLeft > 0)
			begin
				stallLeft--;
				queued1 = 1'b0;
			end
			else if (randBelow(100) == 0)
			begin
				stallLeft = 20 + randBelow(40);
				queued1 = 1'b0;
			end
			else
				queued1 = issue0.valid && randBelow(4) != 0;
			queued2 = queued1 && issue1.valid && randBelow(2) != 0;
			if (branchMiss)
			begin
				queued1 = 1'b0;                         // the flush wins over the queue
				queued2 = 1'b0;
			end

			if (queued1)
				checkSlot("issue0", issue0);
			if (queued2)
				checkSlot("issue1", issue1);

			// model of the coming rising edge
			accept = fetchHit && fetchReady && !branchMiss;
			if (branchMiss)
			begin
				expAdr = missPc;
				buffered = 0;
			end
			else
				buffered = buffered - int'(queued1) - int'(queued2)
					+ (accept ? (takes(insn0, predictTaken0) ? 1 : 2) : 0);
			holdPc = !fetchReady && !branchMiss;
			lastPc = fetchPc;

			cycles++;
			if (cycles >= MaxCycles)
				failNow("timeout: the cycle limit was reached before enough slots were issued");
			@(negedge clk);
		end

		$display("test passed");
		$finish;
	end

endmodule

/* list.f */
design/fetchPkg.sv
design/branchTarget.sv
design/fetchControl.sv
design/fetchPairs.sv
design/fetchBuffer.sv
verif/fetchBufferTb.sv

/* Bender.yml */
package:
  name: fetch_buffer

sources:
  # package first, then leaf modules, then the top level
  - files:
      - design/fetchPkg.sv
      - design/branchTarget.sv
      - design/fetchControl.sv
      - design/fetchPairs.sv
      - design/fetchBuffer.sv

  # testbench
  - target: simulation
    files:
      - verif/fetchBufferTb.sv
